// ==== project.f ====
ppu_pkg.sv
ppu_regs.sv
line_timer.sv
bg_fetcher.sv
pixel_fifo.sv
gb_ppu.sv
gb_ppu_asserts.sv
tb_gb_ppu.sv

// ==== Bender.yml ====
package:
  name: gb_ppu

sources:
  - ppu_pkg.sv
  - ppu_regs.sv
  - line_timer.sv
  - bg_fetcher.sv
  - pixel_fifo.sv
  - gb_ppu.sv
  - target: simulation
    files:
      - gb_ppu_asserts.sv
      - tb_gb_ppu.sv

// ==== tb_gb_ppu.sv ====
`timescale 1ns/1ps

module tb_gb_ppu;

	localparam int clk_period   = 40;
	localparam int frame_clocks = ppu_pkg::dots_per_line * ppu_pkg::lines_per_frame;
	// Four frames cover the start-up lines and the three measured frames.
	localparam int watchdog_clocks = 4 * frame_clocks + 10000;
	// Vertical sync is high on line 0 from dot 6 up to the end of mode 2.
	localparam int vsync_clocks = 80 - 6;

	logic        clk;
	logic        reset;
	logic [3:0]  reg_adr;
	logic [7:0]  reg_din;
	logic        reg_read;
	logic        reg_write;
	logic [7:0]  reg_dout;
	logic        irq_vblank;
	logic        irq_stat;
	logic [7:0]  data;
	logic [15:0] adr;
	logic        read;
	logic [1:0]  px;
	logic        px_valid;
	logic        hsync;
	logic        vsync;

	logic [7:0]  mem [0:65535];
	integer      seed;
	int          errors;
	int          checks;
	int          err_mark;
	int          total;

	// Expected configuration of the frame being captured.
	logic [7:0]  e_scy;
	logic [7:0]  e_scx;
	logic [7:0]  e_bgp;
	logic        e_map_hi;
	logic        e_unsigned;
	logic        cap_on;
	logic        hsync_q;
	int          cap_line;
	int          cap_px;
	int          px_bad;
	int          bad_lines;
	int          vs_count;

	logic [3:0]  rw_adr [9] = '{4'h0, 4'h2, 4'h3, 4'h5, 4'h7, 4'h8, 4'h9, 4'hA, 4'hB};
	logic [7:0]  rw_val [9] = '{8'h5A, 8'h13, 8'h2D, 8'h32, 8'hE4, 8'hC3, 8'h96, 8'h71, 8'h0F};

	gb_ppu gb_ppu_inst (
		.clk        (clk),
		.reset      (reset),
		.reg_adr    (reg_adr),
		.reg_din    (reg_din),
		.reg_read   (reg_read),
		.reg_write  (reg_write),
		.reg_dout   (reg_dout),
		.irq_vblank (irq_vblank),
		.irq_stat   (irq_stat),
		.data       (data),
		.adr        (adr),
		.read       (read),
		.px         (px),
		.px_valid   (px_valid),
		.hsync      (hsync),
		.vsync      (vsync)
	);

	bind gb_ppu gb_ppu_asserts asserts_inst (
		.clk        (clk),
		.reset      (reset),
		.irq_vblank (irq_vblank),
		.irq_stat   (irq_stat),
		.read       (read),
		.px_valid   (px_valid),
		.line       (line)
	);

	always #(clk_period / 2) clk = ~clk;

	// Video memory answers on the falling edge, ahead of the next rising edge.
	always @(negedge clk) begin
		if (read)
			data = mem[adr];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model of the background
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Shade of pixel k on visible line y, taken from the map and tile data.
	function automatic logic [1:0] expected_shade(input int y, input int k);
		logic [7:0] bx;
		logic [7:0] by;
		logic [7:0] tile;
		logic [7:0] lo;
		logic [7:0] hi;
		int         madr;
		int         tadr;
		int         bit_n;
		logic [1:0] idx;
		bx = e_scx + 8'(k);
		by = e_scy + 8'(y);
		madr = (e_map_hi ? ppu_pkg::map_base_hi : ppu_pkg::map_base_lo) +
			32 * int'(by[7:3]) + int'(bx[7:3]);
		tile = mem[madr[15:0]];
		if (e_unsigned)
			tadr = ppu_pkg::tile_base_unsigned + 16 * int'(tile);
		else
			tadr = ppu_pkg::tile_base_signed + 16 * int'($signed(tile));
		tadr = tadr + 2 * int'(by[2:0]);
		lo = mem[tadr[15:0]];
		hi = mem[tadr[15:0] + 16'd1];
		bit_n = 7 - int'(bx[2:0]);
		idx = {hi[bit_n], lo[bit_n]};
		return e_bgp[2 * idx +: 2];
	endfunction

	// Each hsync rise opens a new visible line.
	always @(negedge clk) begin
		if (cap_on) begin
			if (vsync)
				vs_count++;
			if (hsync && !hsync_q) begin
				if (cap_line >= 0)
					assert (cap_px == 160) else begin
						bad_lines++;
						$display("[ERROR] %0t px_valid count line %0d: got %0d expected 160",
							$time, cap_line, cap_px);
					end
				cap_line++;
				cap_px = 0;
			end
			if (px_valid) begin
				assert (px == expected_shade(cap_line, cap_px)) else begin
					px_bad++;
					if (px_bad <= 8)
						$display("[ERROR] %0t px line %0d pixel %0d: got %0d expected %0d",
							$time, cap_line, cap_px, px, expected_shade(cap_line, cap_px));
				end
				cap_px++;
			end
		end
		hsync_q = hsync;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic report(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - err_mark);
		err_mark = errors;
	endtask

	// The write commits on the edge where the strobe is seen low again.
	task automatic reg_wr(input logic [3:0] a, input logic [7:0] d);
		@(negedge clk);
		reg_adr   = a;
		reg_din   = d;
		reg_write = 1'b1;
		@(negedge clk);
		reg_write = 1'b0;
		@(negedge clk);
	endtask

	task automatic reg_rd(input logic [3:0] a, output logic [7:0] d);
		@(negedge clk);
		reg_adr  = a;
		reg_read = 1'b1;
		@(negedge clk);
		d        = reg_dout;
		reg_read = 1'b0;
	endtask

	// Waits for irq_vblank (sel 0) or irq_stat (sel 1), counting clocks and irq_stat.
	task automatic wait_irq(input int sel, input int limit, output int n, output int stats);
		n     = 0;
		stats = 0;
		do begin
			@(negedge clk);
			n++;
			if (irq_stat)
				stats++;
			if (n > limit) begin
				errors++;
				$display("timed out after %0d clocks waiting for %s", n,
					sel == 0 ? "irq_vblank" : "irq_stat");
				return;
			end
		end while (!(sel == 0 ? irq_vblank : irq_stat));
	endtask

	task automatic start_capture(input logic [7:0] scy, input logic [7:0] scx,
		input logic [7:0] bgp, input logic map_hi, input logic tiles_unsigned);
		e_scy      = scy;
		e_scx      = scx;
		e_bgp      = bgp;
		e_map_hi   = map_hi;
		e_unsigned = tiles_unsigned;
		cap_line   = -1;
		cap_px     = 0;
		px_bad     = 0;
		bad_lines  = 0;
		vs_count   = 0;
		cap_on     = 1'b1;
	endtask

	task automatic finish_capture();
		cap_on = 1'b0;
		check("px_valid count last line", cap_px, 160);
		check("visible lines", cap_line + 1, 144);
		check("lines with wrong px_valid count", bad_lines, 0);
		check("pixel mismatches", px_bad, 0);
		check("vsync high clocks", vs_count, vsync_clocks);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [7:0] v;
		int         n;
		int         s;
		int         s_rest;
		int         busy;
		seed = 88;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'($random(seed));
		clk       = 1'b0;
		reset     = 1'b1;
		reg_adr   = 4'h0;
		reg_din   = 8'h00;
		reg_read  = 1'b0;
		reg_write = 1'b0;
		data      = 8'h00;
		cap_on    = 1'b0;
		hsync_q   = 1'b0;
		vs_count  = 0;
		errors    = 0;
		checks    = 0;
		err_mark  = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// LCDC is written with bit 7 clear so the LCD stays off.
		for (int i = 0; i < 9; i++)
			reg_wr(rw_adr[i], rw_val[i]);
		for (int i = 0; i < 9; i++) begin
			reg_rd(rw_adr[i], v);
			check($sformatf("reg_dout offset 0x%h", rw_adr[i]), v, rw_val[i]);
		end
		reg_wr(4'h1, 8'h78);
		reg_rd(4'h1, v);
		check("reg_dout STAT", v, 8'hF8);
		reg_rd(4'h6, v);
		check("reg_dout offset 0x6", v, 8'hFF);
		reg_rd(4'hC, v);
		check("reg_dout offset 0xC", v, 8'hFF);
		reg_rd(4'hF, v);
		check("reg_dout offset 0xF", v, 8'hFF);
		report(1, "register access");

		busy = 0;
		repeat (1000) begin
			@(negedge clk);
			if (read || px_valid || irq_vblank || irq_stat)
				busy++;
		end
		check("outputs active with LCD off", busy, 0);
		reg_rd(4'h4, v);
		check("LY", v, 0);
		reg_rd(4'h1, v);
		check("STAT mode", v[1:0], 0);
		report(2, "LCD off");

		// Mode 0 interrupt select, then the LCD on with 0x8000 tile data.
		reg_wr(4'h1, 8'h08);
		reg_wr(4'h0, 8'h91);
		wait_irq(0, frame_clocks, n, s);
		wait_irq(0, frame_clocks + 1000, n, s);
		check("irq_vblank spacing", n, frame_clocks);
		reg_rd(4'h4, v);
		check("LY after irq_vblank", v, 144);
		report(3, "frame timing");

		check("irq_stat count with sel_mode0", s, 144);
		reg_wr(4'h1, 8'h40);
		start_capture(8'h13, 8'h2D, 8'hE4, 1'b0, 1'b1);
		wait_irq(1, frame_clocks, n, s);
		reg_rd(4'h4, v);
		check("LY at irq_stat", v, 50);
		wait_irq(0, frame_clocks, n, s_rest);
		check("irq_stat count with sel_lyc", s + s_rest, 1);
		report(4, "mode sequence and STAT interrupt");

		finish_capture();
		reg_wr(4'h0, 8'h89);
		reg_wr(4'h2, 8'hF0);
		reg_wr(4'h3, 8'hFB);
		reg_wr(4'h7, 8'h1B);
		start_capture(8'hF0, 8'hFB, 8'h1B, 1'b1, 1'b0);
		wait_irq(0, frame_clocks, n, s);
		finish_capture();
		report(5, "pixel output");

		@(negedge clk);
		total = errors + gb_ppu_inst.asserts_inst.fails;
		$display("summary: 5 tests, %0d checks, %0d errors, %0d assertion failures",
			checks, errors, gb_ppu_inst.asserts_inst.fails);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(watchdog_clocks * clk_period);
		$display("watchdog expired after %0d clocks", watchdog_clocks);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== gb_ppu_asserts.sv ====
`timescale 1ns/1ps

module gb_ppu_asserts (
	input logic                 clk,
	input logic                 reset,
	input logic                 irq_vblank,
	input logic                 irq_stat,
	input logic                 read,
	input logic                 px_valid,
	input ppu_pkg::line_state_t line
);

	// Failure count, read by the testbench when it builds its summary.
	int fails = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Interrupt pulses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	irq_vblank_pulse: assert property (@(posedge clk) disable iff (reset)
		irq_vblank |=> !irq_vblank)
	else begin
		$error("irq_vblank stayed high for more than one clock");
		fails++;
	end

	irq_stat_pulse: assert property (@(posedge clk) disable iff (reset)
		irq_stat |=> !irq_stat)
	else begin
		$error("irq_stat stayed high for more than one clock");
		fails++;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mode rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	vram_read_in_xfer: assert property (@(posedge clk) disable iff (reset)
		read |-> line.mode == ppu_pkg::mode_xfer)
	else begin
		$error("video memory read outside mode 3");
		fails++;
	end

	// The pixel register is loaded from a mode 3 cycle, so the last pixel of
	// a line shows up in the first cycle of mode 0.
	px_from_xfer: assert property (@(posedge clk) disable iff (reset)
		px_valid |-> $past(line.mode) == ppu_pkg::mode_xfer)
	else begin
		$error("pixel strobe not produced by a mode 3 cycle");
		fails++;
	end

	no_xfer_in_vblank: assert property (@(posedge clk) disable iff (reset)
		line.ly >= 8'(ppu_pkg::vblank_line) |->
			line.mode != ppu_pkg::mode_oam && line.mode != ppu_pkg::mode_xfer)
	else begin
		$error("mode 2 or 3 seen on a vertical blank line");
		fails++;
	end

endmodule

// ==== gb_ppu.sv ====
`timescale 1ns/1ps

module gb_ppu (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [ppu_pkg::reg_addr_w-1:0]  reg_adr,
	input  logic [7:0]                      reg_din,
	input  logic                            reg_read,
	input  logic                            reg_write,
	output logic [7:0]                      reg_dout,
	output logic                            irq_vblank,
	output logic                            irq_stat,
	input  logic [7:0]                      data,
	output logic [ppu_pkg::vram_addr_w-1:0] adr,
	output logic                            read,
	output logic [1:0]                      px,
	output logic                            px_valid,
	output logic                            hsync,
	output logic                            vsync
);

	ppu_pkg::ppu_cfg_t    cfg;
	ppu_pkg::line_state_t line;
	ppu_pkg::tile_row_t   row;
	logic                 row_valid;
	logic                 row_take;
	logic                 restart;
	logic                 line_done;
	logic                 hsync_start;

	ppu_regs regs_inst (
		.clk        (clk),
		.reset      (reset),
		.reg_adr    (reg_adr),
		.reg_din    (reg_din),
		.reg_read   (reg_read),
		.reg_write  (reg_write),
		.line       (line),
		.reg_dout   (reg_dout),
		.cfg        (cfg),
		.irq_vblank (irq_vblank),
		.irq_stat   (irq_stat)
	);

	line_timer timer_inst (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg),
		.line_done   (line_done),
		.line        (line),
		.hsync_start (hsync_start),
		.vsync       (vsync)
	);

	bg_fetcher fetcher_inst (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.line      (line),
		.restart   (restart),
		.row_take  (row_take),
		.data      (data),
		.adr       (adr),
		.read      (read),
		.row       (row),
		.row_valid (row_valid)
	);

	pixel_fifo fifo_inst (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg),
		.line        (line),
		.hsync_start (hsync_start),
		.row         (row),
		.row_valid   (row_valid),
		.row_take    (row_take),
		.restart     (restart),
		.line_done   (line_done),
		.hsync       (hsync),
		.px          (px),
		.px_valid    (px_valid)
	);

endmodule

// ==== pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  ppu_pkg::line_state_t line,
	input  logic                 hsync_start,
	input  ppu_pkg::tile_row_t   row,
	input  logic                 row_valid,
	output logic                 row_take,
	output logic                 restart,
	output logic                 line_done,
	output logic                 hsync,
	output logic [1:0]           px,
	output logic                 px_valid
);

	// Two bit-planes, bit 15 is the pixel at the head of the FIFO.
	logic [ppu_pkg::fifo_depth-1:0] lo_q;
	logic [ppu_pkg::fifo_depth-1:0] hi_q;
	logic [ppu_pkg::fifo_depth-1:0] lo_ld;
	logic [ppu_pkg::fifo_depth-1:0] hi_ld;
	logic [4:0]                     len;
	logic [4:0]                     len_ld;
	logic [7:0]                     cnt;
	logic [7:0]                     cnt_eff;
	logic                           scxed;
	logic                           scx_hit;
	logic                           scxed_eff;
	logic                           shift;
	logic [1:0]                     idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load and shift decision
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		lo_ld    = lo_q;
		hi_ld    = hi_q;
		len_ld   = len;
		row_take = row_valid && (len == 5'd0 || len == 5'd8);
		if (row_take) begin
			if (len == 5'd0) begin
				lo_ld[15:8] = row.lo;
				hi_ld[15:8] = row.hi;
			end else begin
				lo_ld[7:0] = row.lo;
				hi_ld[7:0] = row.hi;
			end
			len_ld = len + 5'd8;
		end

		// A row loaded in this cycle can already feed the shift.
		shift = (line.mode == ppu_pkg::mode_xfer) && (len_ld > 5'd8);

		// Once SCX[2:0] pixels are gone the count restarts at 0.
		scx_hit   = shift && !scxed && (cnt == {5'd0, cfg.scx[2:0]});
		scxed_eff = scxed || scx_hit;
		cnt_eff   = scx_hit ? 8'd0 : cnt;
		line_done = shift && scxed_eff && (cnt_eff == 8'(ppu_pkg::line_end_px - 1));
	end

	assign restart = line.line_start || line_done;
	assign idx     = {hi_ld[15], lo_ld[15]};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State and output
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Every line starts with 8 garbage pixels in the upper half.
	always_ff @(posedge clk) begin
		if (reset || !cfg.lcdc.ppu_ena || line.line_start) begin
			len      <= 5'(ppu_pkg::garbage_px);
			cnt      <= 8'd0;
			scxed    <= 1'b0;
			hsync    <= 1'b0;
			px_valid <= 1'b0;
		end else begin
			len      <= shift ? len_ld - 5'd1 : len_ld;
			px_valid <= 1'b0;
			if (hsync_start)
				hsync <= 1'b1;
			if (shift) begin
				cnt   <= cnt_eff + 8'd1;
				scxed <= scxed_eff;
				if (scxed_eff && cnt_eff == 8'(ppu_pkg::garbage_px - 1))
					hsync <= 1'b0;
				px_valid <= scxed_eff && (cnt_eff >= 8'(ppu_pkg::garbage_px));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			lo_q <= {lo_ld[14:0], 1'b0};
			hi_q <= {hi_ld[14:0], 1'b0};
		end else begin
			lo_q <= lo_ld;
			hi_q <= hi_ld;
		end
		// Palette lookup, color index n selects BGP bits 2n+1 and 2n.
		px <= cfg.bgp[{idx, 1'b0} +: 2];
	end

endmodule

// ==== bg_fetcher.sv ====
`timescale 1ns/1ps

module bg_fetcher (
	input  logic                            clk,
	input  logic                            reset,
	input  ppu_pkg::ppu_cfg_t               cfg,
	input  ppu_pkg::line_state_t            line,
	input  logic                            restart,
	input  logic                            row_take,
	input  logic [7:0]                      data,
	output logic [ppu_pkg::vram_addr_w-1:0] adr,
	output logic                            read,
	output ppu_pkg::tile_row_t              row,
	output logic                            row_valid
);

	ppu_pkg::fetch_state_e           state;
	logic [4:0]                      col;
	logic [4:0]                      col_cur;
	logic [7:0]                      bg_line;
	logic                            xfer_start;
	logic [ppu_pkg::vram_addr_w-1:0] map_base;
	logic [ppu_pkg::vram_addr_w-1:0] map_adr;
	logic [ppu_pkg::vram_addr_w-1:0] tile_base;
	logic [ppu_pkg::vram_addr_w-1:0] tile_adr;

	// Background line, bits 7 to 3 select the map row and bits 2 to 0 the tile row.
	assign bg_line    = cfg.scy + line.ly;
	assign xfer_start = (line.mode == ppu_pkg::mode_xfer) &&
		(line.lx == 9'(ppu_pkg::oam_dots));
	assign col_cur    = xfer_start ? cfg.scx[7:3] : col;

	assign map_base = cfg.lcdc.bg_map ? 16'(ppu_pkg::map_base_hi) : 16'(ppu_pkg::map_base_lo);
	assign map_adr  = map_base + {6'd0, bg_line[7:3], col_cur};

	// In the 0x9000 mode the tile number is signed, so tiles 128 to 255 land
	// at 0x8800 to 0x8FF0.
	assign tile_base = cfg.lcdc.bg_tiles ? 16'(ppu_pkg::tile_base_unsigned) :
		16'(ppu_pkg::tile_base_signed);
	assign tile_adr  = tile_base +
		{{4{data[7] & ~cfg.lcdc.bg_tiles}}, data, bg_line[2:0], 1'b0};

	assign row_valid = (state == ppu_pkg::full);

	// Each step issues the next read and captures the data of the previous one.
	always_ff @(posedge clk) begin
		if (reset || restart || !cfg.lcdc.ppu_ena) begin
			state <= ppu_pkg::idle;
			read  <= 1'b0;
		end else begin
			case (state)
				ppu_pkg::idle: begin
					if (line.mode == ppu_pkg::mode_xfer) begin
						state <= ppu_pkg::map_rd;
						read  <= 1'b1;
						adr   <= map_adr;
					end
				end
				ppu_pkg::map_rd: begin
					state <= ppu_pkg::lo_rd;
					adr   <= tile_adr;
				end
				ppu_pkg::lo_rd: begin
					state  <= ppu_pkg::hi_rd;
					adr[0] <= 1'b1;
				end
				ppu_pkg::hi_rd: begin
					state <= ppu_pkg::full;
					read  <= 1'b0;
				end
				ppu_pkg::full: begin
					if (row_take)
						state <= ppu_pkg::idle;
				end
				default: state <= ppu_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ppu_pkg::lo_rd)
			row.lo <= data;
		if (state == ppu_pkg::hi_rd)
			row.hi <= data;
		if (xfer_start)
			col <= cfg.scx[7:3];
		else if (row_valid && row_take)
			col <= col + 5'd1; // Wraps inside the 32-tile map row.
	end

endmodule

// ==== line_timer.sv ====
`timescale 1ns/1ps

module line_timer (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  logic                 line_done,
	output ppu_pkg::line_state_t line,
	output logic                 hsync_start,
	output logic                 vsync
);

	logic [8:0]         lx;
	logic [8:0]         lx_nxt;
	logic [7:0]         ly;
	logic [7:0]         ly_nxt;
	// Internal line count, it runs through all of line 153 while LY does not.
	logic [7:0]         ily;
	logic [7:0]         ily_nxt;
	ppu_pkg::ppu_mode_e mode;
	ppu_pkg::ppu_mode_e mode_nxt;

	always_comb begin
		lx_nxt  = lx + 9'd1;
		ily_nxt = ily;
		ly_nxt  = ly;
		if (lx == 9'(ppu_pkg::dots_per_line - 1)) begin
			lx_nxt  = 9'd0;
			ily_nxt = (ily == 8'(ppu_pkg::lines_per_frame - 1)) ? 8'd0 : ily + 8'd1;
			ly_nxt  = ily_nxt;
		end
		if (ily_nxt == 8'(ppu_pkg::lines_per_frame - 1) &&
			lx_nxt == 9'(ppu_pkg::ly_early_zero_dot))
			ly_nxt = 8'd0;

		// The mode follows the new dot and line so it changes together with them.
		mode_nxt = mode;
		if (ily_nxt >= 8'(ppu_pkg::vblank_line))
			mode_nxt = ppu_pkg::mode_vblank;
		else if (lx_nxt == 9'd0)
			mode_nxt = ppu_pkg::mode_oam;
		else if (lx_nxt == 9'(ppu_pkg::oam_dots))
			mode_nxt = ppu_pkg::mode_xfer;
		else if (line_done)
			mode_nxt = ppu_pkg::mode_hblank;
	end

	// With the LCD off everything is held at the start of line 0 in mode 0.
	always_ff @(posedge clk) begin
		if (reset || !cfg.lcdc.ppu_ena) begin
			lx    <= 9'd0;
			ly    <= 8'd0;
			ily   <= 8'd0;
			mode  <= ppu_pkg::mode_hblank;
			vsync <= 1'b0;
		end else begin
			lx    <= lx_nxt;
			ly    <= ly_nxt;
			ily   <= ily_nxt;
			mode  <= mode_nxt;
			vsync <= (ily_nxt == 8'd0) && (lx_nxt >= 9'(ppu_pkg::vsync_dot)) &&
				(lx_nxt < 9'(ppu_pkg::oam_dots));
		end
	end

	// Announces mode 3 one cycle ahead so that a registered hsync rises with it.
	assign hsync_start = (mode_nxt == ppu_pkg::mode_xfer) && (mode != ppu_pkg::mode_xfer);

	always_comb begin
		line.lx         = lx;
		line.ly         = ly;
		line.mode       = mode;
		line.lyc_eq     = cfg.lcdc.ppu_ena && (ly == cfg.lyc);
		line.line_start = cfg.lcdc.ppu_ena && (lx == 9'd0);
	end

endmodule

// ==== ppu_regs.sv ====
`timescale 1ns/1ps

module ppu_regs (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [ppu_pkg::reg_addr_w-1:0] reg_adr,
	input  logic [7:0]                     reg_din,
	input  logic                           reg_read,
	input  logic                           reg_write,
	input  ppu_pkg::line_state_t           line,
	output logic [7:0]                     reg_dout,
	output ppu_pkg::ppu_cfg_t              cfg,
	output logic                           irq_vblank,
	output logic                           irq_stat
);

	logic           read_q;
	logic           write_q;
	ppu_pkg::lcdc_t lcdc;
	logic           sel_lyc;
	logic           sel_mode2;
	logic           sel_mode1;
	logic           sel_mode0;
	logic [7:0]     scy;
	logic [7:0]     scx;
	logic [7:0]     lyc;
	logic [7:0]     bgp;
	logic [7:0]     obp0;
	logic [7:0]     obp1;
	logic [7:0]     wy;
	logic [7:0]     wx;
	logic           stat_cond;
	logic           stat_cond_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A write commits on the falling edge of the write strobe and a read
	// is answered on the rising edge of the read strobe.
	always_ff @(posedge clk) begin
		if (reset) begin
			read_q      <= 1'b0;
			write_q     <= 1'b0;
			stat_cond_q <= 1'b0;
			reg_dout    <= 8'h00;
			lcdc        <= '0;
			{sel_lyc, sel_mode2, sel_mode1, sel_mode0} <= 4'h0;
			{scy, scx, lyc, bgp} <= '0;
			{obp0, obp1, wy, wx} <= '0;
		end else begin
			read_q      <= reg_read;
			write_q     <= reg_write;
			stat_cond_q <= stat_cond;
			if (write_q && !reg_write) begin
				case (reg_adr)
					4'h0: lcdc <= reg_din;
					4'h1: {sel_lyc, sel_mode2, sel_mode1, sel_mode0} <= reg_din[6:3];
					4'h2: scy  <= reg_din;
					4'h3: scx  <= reg_din;
					4'h5: lyc  <= reg_din;
					4'h7: bgp  <= reg_din;
					4'h8: obp0 <= reg_din;
					4'h9: obp1 <= reg_din;
					4'hA: wy   <= reg_din;
					4'hB: wx   <= reg_din;
					default: ;
				endcase
			end
			if (!read_q && reg_read) begin
				case (reg_adr)
					4'h0: reg_dout <= lcdc;
					4'h1: reg_dout <= {1'b1, sel_lyc, sel_mode2, sel_mode1, sel_mode0,
						line.lyc_eq, line.mode};
					4'h2: reg_dout <= scy;
					4'h3: reg_dout <= scx;
					4'h4: reg_dout <= line.ly;
					4'h5: reg_dout <= lyc;
					4'h7: reg_dout <= bgp;
					4'h8: reg_dout <= obp0;
					4'h9: reg_dout <= obp1;
					4'hA: reg_dout <= wy;
					4'hB: reg_dout <= wx;
					default: reg_dout <= 8'hFF;
				endcase
			end
		end
	end

	assign cfg = '{lcdc: lcdc, scy: scy, scx: scx, lyc: lyc, bgp: bgp};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Interrupts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The mode 1 interrupt also fires with only the mode 2 select set.
	assign stat_cond = lcdc.ppu_ena && (
		(line.lyc_eq && sel_lyc) ||
		(line.mode == ppu_pkg::mode_hblank && sel_mode0) ||
		(line.mode == ppu_pkg::mode_vblank && (sel_mode1 || sel_mode2)) ||
		(line.mode == ppu_pkg::mode_oam && sel_mode2));

	assign irq_stat   = stat_cond && !stat_cond_q;
	assign irq_vblank = (line.lx == 9'd0) && (line.ly == 8'(ppu_pkg::vblank_line));

endmodule

// ==== ppu_pkg.sv ====
package ppu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Line and frame timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int dots_per_line     = 456;
	localparam int lines_per_frame   = 154;
	localparam int vblank_line       = 144;
	// Mode 3 begins at this dot of every visible line.
	localparam int oam_dots          = 80;
	// LY already reads 0 from this dot of line 153 on.
	localparam int ly_early_zero_dot = 8;
	// The vertical sync level rises at this dot of line 0.
	localparam int vsync_dot         = 6;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixel pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Pixel count that ends mode 3, which is 8 dropped plus 160 visible.
	localparam int line_end_px = 168;
	localparam int garbage_px  = 8;
	localparam int fifo_depth  = 16;

	// Video memory map.
	localparam int map_base_lo        = 'h9800;
	localparam int map_base_hi        = 'h9C00;
	localparam int tile_base_unsigned = 'h8000;
	localparam int tile_base_signed   = 'h9000;

	localparam int reg_addr_w  = 4;
	localparam int vram_addr_w = 16;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		mode_hblank = 2'd0,
		mode_vblank = 2'd1,
		mode_oam    = 2'd2,
		mode_xfer   = 2'd3
	} ppu_mode_e;

	// Bit order follows the LCDC register, ppu_ena is bit 7.
	typedef struct packed {
		logic ppu_ena;
		logic win_map;
		logic win_ena;
		logic bg_tiles;
		logic bg_map;
		logic obj_size;
		logic obj_ena;
		logic bg_ena;
	} lcdc_t;

	typedef struct packed {
		lcdc_t      lcdc;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		logic [7:0] bgp;
	} ppu_cfg_t;

	typedef struct packed {
		logic [8:0] lx;
		logic [7:0] ly;
		ppu_mode_e  mode;
		logic       lyc_eq;
		logic       line_start;
	} line_state_t;

	// One row of a tile, bit 7 of each plane is the leftmost pixel.
	typedef struct packed {
		logic [7:0] lo;
		logic [7:0] hi;
	} tile_row_t;

	typedef enum logic [2:0] {
		idle,
		map_rd,
		lo_rd,
		hi_rd,
		full
	} fetch_state_e;

endpackage
